//--- Makefile
TOP := regReadTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	  test $$status -eq 0 && ! grep -q "Test failed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- build.f
logic/physRegPkg.sv
logic/issuePktPkg.sv
logic/physRegFile.sv
logic/operandBypass.sv
logic/readyScoreboard.sv
logic/regReadStage.sv
sim/regRead_properties.sv
sim/regReadTb.sv

//--- logic/issuePktPkg.sv
// opcode classes and branch mask type.
// issue packet, operand packet and branch squash request.
`default_nettype none

package issuePktPkg;

  import physRegPkg::*;

  localparam int numIssueLanes  = 2;
  localparam int numCheckpoints = 4;

  typedef logic [$clog2(numCheckpoints)-1:0] ckptId_t;
  typedef logic [numCheckpoints-1:0]         brMask_t;

  // passed through the stage untouched.
  typedef enum logic [2:0] {
    OP_ALU    = 3'd0,
    OP_MUL    = 3'd1,
    OP_LOAD   = 3'd2,
    OP_STORE  = 3'd3,
    OP_BRANCH = 3'd4
  } opClass_t;

  typedef struct packed {
    logic     valid;
    brMask_t  brMask;
    physTag_t src1;
    physTag_t src2;
    physTag_t dest;
    opClass_t opClass;
  } issuePkt_t;

  typedef struct packed {
    issuePkt_t pkt;
    regData_t  src1Data;
    regData_t  src2Data;
  } operandPkt_t;

  // branch resolution from execute.
  typedef struct packed {
    logic    verified;
    logic    mispredict;
    ckptId_t ckptId;
  } squashReq_t;

endpackage

`default_nettype wire

//--- logic/operandBypass.sv
// source operand selection.
// writeback bus tag match with register file fallback.
`default_nettype none

module operandBypass
  import physRegPkg::*;
(
  input  physTag_t rdTags_i   [numReadPorts],
  input  regData_t fileData_i [numReadPorts],
  input  wbPkt_t   wbLanes_i  [numWbLanes],
  output regData_t operands_o [numReadPorts]
);

  logic [numWbLanes-1:0] hit [numReadPorts];

  // tag compare per read port and lane.
  always_comb begin
    for (int p = 0; p < numReadPorts; p++) begin
      for (int l = 0; l < numWbLanes; l++) begin
        hit[p][l] = wbLanes_i[l].valid && (wbLanes_i[l].dest == rdTags_i[p]);
      end
    end
  end

  // scan from the top lane down so the lowest hit is the last one taken.
  always_comb begin
    for (int p = 0; p < numReadPorts; p++) begin
      operands_o[p] = fileData_i[p];
      for (int l = numWbLanes - 1; l >= 0; l--) begin
        if (hit[p][l]) begin
          operands_o[p] = wbLanes_i[l].data;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/physRegFile.sv
// physical register storage.
// four asynchronous read ports, one write port per writeback lane.
`default_nettype none

module physRegFile
  import physRegPkg::*;
(
  input  wire logic clk,
  input  physTag_t  rdTags_i  [numReadPorts],
  output regData_t  rdData_o  [numReadPorts],
  input  wbPkt_t    wbLanes_i [numWbLanes],
  input  wire logic recover_i
);

  regData_t regs [numPhysRegs];

  // ==========================================================================
  // read ports
  // ==========================================================================

  always_comb begin
    for (int p = 0; p < numReadPorts; p++) begin
      rdData_o[p] = regs[rdTags_i[p]];
    end
  end

  // ==========================================================================
  // write ports
  // ==========================================================================

  // lanes written in order, so the higher lane wins on a shared dest.
  always_ff @(posedge clk) begin
    for (int l = 0; l < numWbLanes; l++) begin
      if (wbLanes_i[l].valid && !recover_i) begin
        regs[wbLanes_i[l].dest] <= wbLanes_i[l].data;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/physRegPkg.sv
// physical register file sizes, tag and data types.
// writeback lane packet and scoreboard update types.
`default_nettype none

package physRegPkg;

  localparam int numPhysRegs = 32;
  localparam int physTagBits = 5;
  localparam int numArchRegs = 8;   // mapped at reset.
  localparam int dataBits    = 32;
  localparam int numWbLanes  = 2;
  localparam int numReadPorts = 4;  // two sources per issue lane.
  localparam int numTagPorts = 2;   // unmap and wakeup ports each.

  typedef logic [physTagBits-1:0] physTag_t;
  typedef logic [dataBits-1:0]    regData_t;
  typedef logic [numPhysRegs-1:0] readyVec_t;

  // one writeback lane, also the bypass source.
  typedef struct packed {
    logic     valid;
    physTag_t dest;
    regData_t data;
  } wbPkt_t;

  // unmap or wakeup request for the scoreboard.
  typedef struct packed {
    logic     valid;
    physTag_t tag;
  } tagReq_t;

  // architectural registers hold values after reset.
  localparam readyVec_t readyResetVec =
    {{(numPhysRegs-numArchRegs){1'b0}}, {numArchRegs{1'b1}}};

endpackage

`default_nettype wire

//--- logic/readyScoreboard.sv
// ready bit per physical register.
// unmap clears, wakeup and writeback sets, exception restore.
`default_nettype none

module readyScoreboard
  import physRegPkg::*;
(
  input  wire logic clk,
  input  wire logic rst_i,
  input  wire logic exception_i,
  input  tagReq_t   unmapLanes_i [numTagPorts],
  input  tagReq_t   wakeTags_i   [numTagPorts],
  input  wbPkt_t    wbLanes_i    [numWbLanes],
  output readyVec_t physRegReady_o
);

  readyVec_t readyQ;
  readyVec_t readyNext;

  always_comb begin
    readyNext = readyQ;
    for (int u = 0; u < numTagPorts; u++) begin
      if (unmapLanes_i[u].valid) readyNext[unmapLanes_i[u].tag] = 1'b0;
    end
    // sets come last and beat a clear of the same register.
    for (int w = 0; w < numTagPorts; w++) begin
      if (wakeTags_i[w].valid) readyNext[wakeTags_i[w].tag] = 1'b1;
    end
    for (int l = 0; l < numWbLanes; l++) begin
      if (wbLanes_i[l].valid) readyNext[wbLanes_i[l].dest] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i || exception_i) begin
      readyQ <= readyResetVec;  // back to the architectural map.
    end else begin
      readyQ <= readyNext;
    end
  end

  assign physRegReady_o = readyQ;

endmodule

`default_nettype wire

//--- logic/regReadStage.sv
// register read stage top level.
// register file, operand bypass, ready scoreboard, squash and output register.
`default_nettype none

module regReadStage
  import physRegPkg::*;
  import issuePktPkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_i,
  input  issuePkt_t  issueLanes_i [numIssueLanes],
  input  wbPkt_t     wbLanes_i    [numWbLanes],
  input  squashReq_t squash_i,
  input  wire logic  recover_i,
  input  wire logic  exception_i,
  input  tagReq_t    unmapLanes_i [numTagPorts],
  input  tagReq_t    wakeTags_i   [numTagPorts],
  output operandPkt_t readLanes_o [numIssueLanes],
  output readyVec_t  physRegReady_o
);

  physTag_t    rdTags   [numReadPorts];
  regData_t    fileData [numReadPorts];
  regData_t    operands [numReadPorts];
  issuePkt_t   issueLive [numIssueLanes];
  logic        mispredictEvent;
  operandPkt_t readQ    [numIssueLanes];

  // ==========================================================================
  // source tags, two read ports per lane
  // ==========================================================================

  always_comb begin
    for (int l = 0; l < numIssueLanes; l++) begin
      rdTags[2*l]   = issueLanes_i[l].src1;
      rdTags[2*l+1] = issueLanes_i[l].src2;
    end
  end

  physRegFile u_regFile (
    .clk       (clk),
    .rdTags_i  (rdTags),
    .rdData_o  (fileData),
    .wbLanes_i (wbLanes_i),
    .recover_i (recover_i)
  );

  // forwarding ignores recovery.
  operandBypass u_bypass (
    .rdTags_i   (rdTags),
    .fileData_i (fileData),
    .wbLanes_i  (wbLanes_i),
    .operands_o (operands)
  );

  readyScoreboard u_ready (
    .clk            (clk),
    .rst_i          (rst_i),
    .exception_i    (exception_i),
    .unmapLanes_i   (unmapLanes_i),
    .wakeTags_i     (wakeTags_i),
    .wbLanes_i      (wbLanes_i),
    .physRegReady_o (physRegReady_o)
  );

  // ==========================================================================
  // mispredict squash
  // ==========================================================================

  assign mispredictEvent = squash_i.verified && squash_i.mispredict;

  always_comb begin
    for (int l = 0; l < numIssueLanes; l++) begin
      issueLive[l] = issueLanes_i[l];
      // lane depends on the bad checkpoint.
      if (mispredictEvent && issueLanes_i[l].brMask[squash_i.ckptId]) begin
        issueLive[l].valid = 1'b0;
      end
    end
  end

  // ==========================================================================
  // output pipeline register
  // ==========================================================================

  always_ff @(posedge clk) begin
    for (int l = 0; l < numIssueLanes; l++) begin
      readQ[l].pkt      <= issueLive[l];
      readQ[l].src1Data <= operands[2*l];
      readQ[l].src2Data <= operands[2*l+1];
      if (rst_i) readQ[l].pkt.valid <= 1'b0;  // only valid is cleared.
    end
  end

  assign readLanes_o = readQ;

endmodule

`default_nettype wire

//--- sim/regReadTb.sv
// register read stage testbench.
// stimulus table, reference model, compare tasks and timeout.
`default_nettype none

module regReadTb
  import physRegPkg::*;
  import issuePktPkg::*;
();

  // one table row, everything driven in one cycle.
  typedef struct packed {
    issuePkt_t [numIssueLanes-1:0] issue;
    wbPkt_t    [numWbLanes-1:0]    wb;
    squashReq_t                    squash;
    logic                          recover;
    logic                          exception;
    tagReq_t   [numTagPorts-1:0]   unmap;
    tagReq_t   [numTagPorts-1:0]   wake;
  } stimRow_t;

  logic        clk = 1'b0;
  logic        rst_i;
  issuePkt_t   issueLanes [numIssueLanes];
  wbPkt_t      wbLanes    [numWbLanes];
  squashReq_t  squash;
  logic        recover;
  logic        exception;
  tagReq_t     unmapLanes [numTagPorts];
  tagReq_t     wakeTags   [numTagPorts];
  operandPkt_t readLanes  [numIssueLanes];
  readyVec_t   physRegReady;

  stimRow_t    stimTable [$];
  regData_t    shadowRegs [numPhysRegs];
  readyVec_t   shadowReady;
  operandPkt_t expLanes [numIssueLanes];
  readyVec_t   expReady;
  integer      seed;
  int          errorCount = 0;
  int          checkCount = 0;
  int          cycleCount = 0;
  int          cycleLimit = 100000;

  regReadStage u_dut (
    .clk            (clk),
    .rst_i          (rst_i),
    .issueLanes_i   (issueLanes),
    .wbLanes_i      (wbLanes),
    .squash_i       (squash),
    .recover_i      (recover),
    .exception_i    (exception),
    .unmapLanes_i   (unmapLanes),
    .wakeTags_i     (wakeTags),
    .readLanes_o    (readLanes),
    .physRegReady_o (physRegReady)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Test failed");
      $finish;
    end
  end

  // ==========================================================================
  // row builders
  // ==========================================================================

  function automatic logic [31:0] nextRand();
    nextRand = $random(seed);
  endfunction

  function automatic readyVec_t archPattern();
    readyVec_t v;
    for (int i = 0; i < numPhysRegs; i++) v[i] = (i < numArchRegs);
    return v;
  endfunction

  function automatic issuePkt_t makeIssue(input logic valid, input brMask_t mask,
                                          input physTag_t s1, input physTag_t s2,
                                          input physTag_t dest, input opClass_t op);
    issuePkt_t p;
    p.valid   = valid;
    p.brMask  = mask;
    p.src1    = s1;
    p.src2    = s2;
    p.dest    = dest;
    p.opClass = op;
    return p;
  endfunction

  function automatic wbPkt_t makeWb(input physTag_t dest, input regData_t data);
    wbPkt_t w;
    w.valid = 1'b1;
    w.dest  = dest;
    w.data  = data;
    return w;
  endfunction

  function automatic tagReq_t makeTag(input physTag_t tag);
    tagReq_t t;
    t.valid = 1'b1;
    t.tag   = tag;
    return t;
  endfunction

  function automatic stimRow_t idleRow();
    stimRow_t r;
    r = '0;
    return r;
  endfunction

  function automatic opClass_t pickOp(input logic [2:0] sel);
    case (sel)
      3'd0:    return OP_ALU;
      3'd1:    return OP_MUL;
      3'd2:    return OP_LOAD;
      3'd3:    return OP_STORE;
      default: return OP_BRANCH;
    endcase
  endfunction

  function automatic stimRow_t randomRow();
    stimRow_t    r;
    logic [31:0] ctl;
    logic [31:0] t;
    r   = idleRow();
    ctl = nextRand();
    for (int l = 0; l < numIssueLanes; l++) begin
      t = nextRand();
      r.issue[l] = makeIssue(ctl[l], t[3:0], t[8:4], t[13:9], t[18:14], pickOp(t[21:19]));
    end
    for (int l = 0; l < numWbLanes; l++) begin
      t = nextRand();
      if (ctl[2+l]) r.wb[l] = makeWb(t[4:0], nextRand());
    end
    r.recover   = (ctl[7:4] == 4'd0);
    r.exception = (ctl[11:8] == 4'd0);
    r.squash    = '{ctl[12], ctl[13], ctl[15:14]};
    t = nextRand();
    for (int p = 0; p < numTagPorts; p++) begin
      if (ctl[16+p]) r.unmap[p] = makeTag(t[5*p +: 5]);
      if (ctl[18+p]) r.wake[p]  = makeTag(t[10+5*p +: 5]);
    end
    return r;
  endfunction

  task automatic buildTable();
    stimRow_t r;
    // fill every register so each later read has a known value.
    for (int k = 0; k < numPhysRegs / 2; k++) begin
      r = idleRow();
      r.wb[0] = makeWb(physTag_t'(2*k), nextRand());
      r.wb[1] = makeWb(physTag_t'(2*k+1), nextRand());
      stimTable.push_back(r);
    end
    r = idleRow();
    r.exception = 1'b1;
    stimTable.push_back(r);
    // write then read back.
    r = idleRow();
    r.wb[0] = makeWb(5'd10, 32'hcafe_0010);
    stimTable.push_back(r);
    r = idleRow();
    r.issue[0] = makeIssue(1'b1, 4'b0000, 5'd10, 5'd11, 5'd20, OP_ALU);
    r.issue[1] = makeIssue(1'b1, 4'b0001, 5'd3, 5'd10, 5'd21, OP_MUL);
    stimTable.push_back(r);
    // same-cycle forwarding, both lanes hit register 12.
    r = idleRow();
    r.wb[0] = makeWb(5'd12, 32'h1111_aaaa);
    r.wb[1] = makeWb(5'd12, 32'h2222_bbbb);
    r.issue[0] = makeIssue(1'b1, 4'b0000, 5'd12, 5'd13, 5'd22, OP_LOAD);
    r.issue[1] = makeIssue(1'b1, 4'b0000, 5'd13, 5'd12, 5'd23, OP_STORE);
    stimTable.push_back(r);
    r = idleRow();
    r.wb[1] = makeWb(5'd13, 32'h3333_cccc);
    r.issue[0] = makeIssue(1'b1, 4'b0000, 5'd12, 5'd13, 5'd24, OP_ALU);
    stimTable.push_back(r);
    // mispredict squash on checkpoints 2 and 0, then an unverified one.
    r = idleRow();
    r.squash   = '{1'b1, 1'b1, 2'd2};
    r.issue[0] = makeIssue(1'b1, 4'b0100, 5'd1, 5'd2, 5'd24, OP_BRANCH);
    r.issue[1] = makeIssue(1'b1, 4'b1011, 5'd3, 5'd4, 5'd25, OP_MUL);
    stimTable.push_back(r);
    r.squash = '{1'b0, 1'b1, 2'd2};
    stimTable.push_back(r);
    r.squash = '{1'b1, 1'b1, 2'd0};
    stimTable.push_back(r);
    // write during recovery is forwarded but not stored.
    r = idleRow();
    r.recover  = 1'b1;
    r.wb[0]    = makeWb(5'd14, 32'hdead_0014);
    r.issue[0] = makeIssue(1'b1, 4'b0000, 5'd14, 5'd14, 5'd26, OP_ALU);
    stimTable.push_back(r);
    r = idleRow();
    r.issue[0] = makeIssue(1'b1, 4'b0000, 5'd14, 5'd15, 5'd27, OP_ALU);
    stimTable.push_back(r);
    // scoreboard clears, sets and restore.
    r = idleRow();
    r.unmap[0] = makeTag(5'd3);
    r.unmap[1] = makeTag(5'd5);
    r.wake[0]  = makeTag(5'd20);
    stimTable.push_back(r);
    r = idleRow();
    r.unmap[0] = makeTag(5'd20);
    r.wake[1]  = makeTag(5'd20);
    r.unmap[1] = makeTag(5'd6);
    r.wb[0]    = makeWb(5'd6, 32'h0000_0606);
    stimTable.push_back(r);
    r = idleRow();
    r.exception = 1'b1;
    r.unmap[0]  = makeTag(5'd1);
    stimTable.push_back(r);
    for (int i = 0; i < 48; i++) stimTable.push_back(randomRow());
  endtask

  // ==========================================================================
  // drive, model and compare
  // ==========================================================================

  task automatic driveInputs(input stimRow_t r);
    for (int l = 0; l < numIssueLanes; l++) issueLanes[l] = r.issue[l];
    for (int l = 0; l < numWbLanes; l++) wbLanes[l] = r.wb[l];
    for (int p = 0; p < numTagPorts; p++) begin
      unmapLanes[p] = r.unmap[p];
      wakeTags[p]   = r.wake[p];
    end
    squash    = r.squash;
    recover   = r.recover;
    exception = r.exception;
  endtask

  // lowest matching writeback lane, else the stored value.
  function automatic regData_t modelOperand(input physTag_t tag, input stimRow_t r);
    regData_t v;
    logic     found;
    v     = shadowRegs[tag];
    found = 1'b0;
    for (int l = 0; l < numWbLanes; l++) begin
      if (!found && r.wb[l].valid && r.wb[l].dest == tag) begin
        v     = r.wb[l].data;
        found = 1'b1;
      end
    end
    return v;
  endfunction

  task automatic predictRow(input stimRow_t r);
    for (int l = 0; l < numIssueLanes; l++) begin
      expLanes[l].pkt      = r.issue[l];
      expLanes[l].src1Data = modelOperand(r.issue[l].src1, r);
      expLanes[l].src2Data = modelOperand(r.issue[l].src2, r);
      if (r.squash.verified && r.squash.mispredict && r.issue[l].brMask[r.squash.ckptId])
        expLanes[l].pkt.valid = 1'b0;
    end
    for (int l = 0; l < numWbLanes; l++) begin
      if (r.wb[l].valid && !r.recover) shadowRegs[r.wb[l].dest] = r.wb[l].data;
    end
    if (r.exception) begin
      shadowReady = archPattern();
    end else begin
      for (int p = 0; p < numTagPorts; p++)
        if (r.unmap[p].valid) shadowReady[r.unmap[p].tag] = 1'b0;
      for (int p = 0; p < numTagPorts; p++)
        if (r.wake[p].valid) shadowReady[r.wake[p].tag] = 1'b1;
      for (int l = 0; l < numWbLanes; l++)
        if (r.wb[l].valid) shadowReady[r.wb[l].dest] = 1'b1;
    end
    expReady = shadowReady;
  endtask

  task automatic checkOperand(input int lane, input operandPkt_t got, input operandPkt_t exp);
    checkCount++;
    if (got.pkt.valid !== exp.pkt.valid) begin
      errorCount++;
      $display("MISMATCH readLanes_o[%0d].pkt.valid: got %h, expected %h",
               lane, got.pkt.valid, exp.pkt.valid);
    end else if (exp.pkt.valid) begin
      if (got.pkt !== exp.pkt) begin
        errorCount++;
        $display("MISMATCH readLanes_o[%0d].pkt: got %h, expected %h", lane, got.pkt, exp.pkt);
      end
      if (got.src1Data !== exp.src1Data) begin
        errorCount++;
        $display("MISMATCH readLanes_o[%0d].src1Data: got %h, expected %h",
                 lane, got.src1Data, exp.src1Data);
      end
      if (got.src2Data !== exp.src2Data) begin
        errorCount++;
        $display("MISMATCH readLanes_o[%0d].src2Data: got %h, expected %h",
                 lane, got.src2Data, exp.src2Data);
      end
    end
  endtask

  task automatic checkReady(input readyVec_t got, input readyVec_t exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("MISMATCH physRegReady_o: got %h, expected %h", got, exp);
    end
  endtask

  task automatic checkOutputs();
    for (int l = 0; l < numIssueLanes; l++) checkOperand(l, readLanes[l], expLanes[l]);
    checkReady(physRegReady, expReady);
  endtask

  initial begin
    seed  = 32'h49c1_fd24;
    rst_i = 1'b1;
    driveInputs(idleRow());
    for (int i = 0; i < numPhysRegs; i++) shadowRegs[i] = '0;
    for (int l = 0; l < numIssueLanes; l++) expLanes[l] = '0;
    shadowReady = archPattern();
    expReady    = shadowReady;
    buildTable();
    cycleLimit = stimTable.size() + 20;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    for (int i = 0; i < stimTable.size(); i++) begin
      checkOutputs();  // results of the previous row.
      driveInputs(stimTable[i]);
      predictRow(stimTable[i]);
      @(negedge clk);
    end
    checkOutputs();
    driveInputs(idleRow());
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/regRead_properties.sv
// concurrent assertions on the register read stage.
// reset behavior of the output lanes and the ready vector.
`default_nettype none

module regRead_properties
  import physRegPkg::*;
  import issuePktPkg::*;
(
  input wire logic   clk,
  input wire logic   rst_i,
  input issuePkt_t   issueLanes_i [numIssueLanes],
  input operandPkt_t readLanes_o  [numIssueLanes],
  input readyVec_t   physRegReady_o
);

  readyVec_t archReady;

  // registers below numArchRegs hold values after reset.
  always_comb begin
    for (int i = 0; i < numPhysRegs; i++) begin
      archReady[i] = (i < numArchRegs);
    end
  end

  for (genvar l = 0; l < numIssueLanes; l++) begin : gLane
    resetClearsValid: assert property (
      @(posedge clk) rst_i |=> !readLanes_o[l].pkt.valid)
      else $error("lane %0d output valid set right after reset", l);

    // squash may drop an item, never create one.
    validFromInput: assert property (
      @(posedge clk) disable iff (rst_i)
      readLanes_o[l].pkt.valid |-> $past(issueLanes_i[l].valid))
      else $error("lane %0d output valid without an input item", l);
  end

  resetReadyPattern: assert property (
    @(posedge clk) rst_i |=> (physRegReady_o == archReady))
    else $error("ready vector differs from the architectural map after reset");

endmodule

bind regReadStage regRead_properties u_props (
  .clk            (clk),
  .rst_i          (rst_i),
  .issueLanes_i   (issueLanes_i),
  .readLanes_o    (readLanes_o),
  .physRegReady_o (physRegReady_o)
);

`default_nettype wire
